// ==== bf16_vector_unit.f ====
logic/bf16_types_pkg.sv
logic/fpu_ctrl_pkg.sv
logic/lane_if.sv
logic/bf16_add.sv
logic/bf16_mul.sv
logic/fpu_lane.sv
logic/lane_dispatch.sv
logic/lane_gather.sv
logic/bf16_vector_unit.sv
test/vector_checker.sv
test/tb_bf16_vector_unit.sv

// ==== logic/bf16_add.sv ====
module bf16_add
	import bf16_types_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic subtract,
	input bf16_t a,
	input bf16_t b,
	output logic data_valid,
	output bf16_t data
);

	typedef enum logic
	{
		add_idle,
		add_normalize
	} add_state_t;

	add_state_t state;

	logic b_sign;
	logic big_sign;
	logic small_sign;
	bf16_exp_t big_exp;
	bf16_exp_t small_exp;
	bf16_exp_t exp_diff;
	bf16_sig_t big_sig;
	bf16_sig_t small_sig;
	bf16_sig_t small_aligned;
	logic [8:0] sum;

	logic res_sign;
	bf16_exp_t res_exp;
	logic [8:0] res_sig;

	logic norm_done;
	bf16_t norm_data;

	function automatic bf16_sig_t significand(input bf16_t x);
		return (x[14:7] == '0) ? '0 : {1'b1, x[6:0]};
	endfunction

	// the larger magnitude sets the result sign, so the difference is never negative.
	always_comb
	begin
		b_sign = b[15] ^ subtract;
		if (a[14:0] >= b[14:0])
		begin
			big_sign = a[15];
			small_sign = b_sign;
			big_exp = a[14:7];
			small_exp = b[14:7];
			big_sig = significand(a);
			small_sig = significand(b);
		end
		else
		begin
			big_sign = b_sign;
			small_sign = a[15];
			big_exp = b[14:7];
			small_exp = a[14:7];
			big_sig = significand(b);
			small_sig = significand(a);
		end
		exp_diff = big_exp - small_exp;
		small_aligned = small_sig >> exp_diff;
		if (big_sign != small_sign)
		begin
			sum = {1'b0, big_sig} - {1'b0, small_aligned};
		end
		else
		begin
			sum = {1'b0, big_sig} + {1'b0, small_aligned};
		end
	end

	// norm_done low means one more left shift is needed.
	always_comb
	begin
		norm_done = 1'b1;
		norm_data = '0;
		if (res_sig == '0)
		begin
			norm_data = '0;
		end
		else if (res_sig[8])
		begin
			if (res_exp == 8'd254)
			begin
				norm_data = {res_sign, 8'hff, 7'h00};
			end
			else
			begin
				norm_data = {res_sign, res_exp + 8'd1, res_sig[7:1]};
			end
		end
		else if (res_sig[7])
		begin
			norm_data = {res_sign, res_exp, res_sig[6:0]};
		end
		else if (res_exp == 8'd1)
		begin
			norm_data = '0;
		end
		else
		begin
			norm_done = 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= add_idle;
			data_valid <= 1'b0;
		end
		else
		begin
			data_valid <= 1'b0;
			case (state)
			add_idle:
			begin
				if (start)
				begin
					res_sign <= big_sign;
					res_exp <= big_exp;
					res_sig <= sum;
					state <= add_normalize;
				end
			end
			add_normalize:
			begin
				if (norm_done)
				begin
					data <= norm_data;
					data_valid <= 1'b1;
					state <= add_idle;
				end
				else
				begin
					res_sig <= res_sig << 1;
					res_exp <= res_exp - 8'd1;
				end
			end
			endcase
		end
	end

endmodule

// ==== logic/bf16_mul.sv ====
module bf16_mul
	import bf16_types_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input bf16_t a,
	input bf16_t b,
	output logic data_valid,
	output bf16_t data
);

	bf16_exp_t a_exp;
	bf16_exp_t b_exp;
	bf16_sig_t a_sig;
	bf16_sig_t b_sig;

	logic stage_valid;
	logic prod_sign;
	logic [15:0] prod_sig;
	logic signed [9:0] prod_exp;

	logic signed [9:0] norm_exp;
	logic [6:0] norm_mant;

	always_comb
	begin
		a_exp = a[14:7];
		b_exp = b[14:7];
		a_sig = (a_exp == '0) ? '0 : {1'b1, a[6:0]};
		b_sig = (b_exp == '0) ? '0 : {1'b1, b[6:0]};
	end

	// the product of two significands in [1,2) lies in [1,4), so one shift is enough.
	always_comb
	begin
		if (prod_sig[15])
		begin
			norm_exp = prod_exp + 10'sd1;
			norm_mant = prod_sig[14:8];
		end
		else
		begin
			norm_exp = prod_exp;
			norm_mant = prod_sig[13:7];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stage_valid <= 1'b0;
			data_valid <= 1'b0;
		end
		else
		begin
			stage_valid <= start;
			data_valid <= stage_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			prod_sign <= a[15] ^ b[15];
			prod_sig <= a_sig * b_sig;
			prod_exp <= $signed({2'b00, a_exp}) + $signed({2'b00, b_exp})
				- $signed({2'b00, bf16_exp_bias});
		end
		if (stage_valid)
		begin
			if ((prod_sig == '0) || (norm_exp <= 10'sd0))
			begin
				data <= '0;
			end
			else if (norm_exp >= 10'sd255)
			begin
				data <= {prod_sign, 8'hff, 7'h00};
			end
			else
			begin
				data <= {prod_sign, norm_exp[7:0], norm_mant};
			end
		end
	end

endmodule

// ==== logic/bf16_types_pkg.sv ====
package bf16_types_pkg;

	localparam int bf16_width = 16;
	localparam int bf16_exp_width = 8;
	localparam int bf16_mant_width = 7;

	// a bfloat16 word holds the sign, the exponent and the mantissa.
	typedef logic [bf16_width-1:0] bf16_t;

	typedef logic [bf16_exp_width-1:0] bf16_exp_t;

	// significand with the hidden bit in the top position.
	typedef logic [bf16_mant_width:0] bf16_sig_t;

	localparam bf16_exp_t bf16_exp_bias = 8'd127;

endpackage

// ==== logic/bf16_vector_unit.sv ====
module bf16_vector_unit
	import bf16_types_pkg::*, fpu_ctrl_pkg::*;
#(
	parameter int num_lanes = 4
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input fpu_oper_t oper,
	input bf16_t [num_lanes-1:0] vec_a,
	input bf16_t [num_lanes-1:0] vec_b,
	output logic can_accept_cmd,
	output logic data_valid,
	output bf16_t [num_lanes-1:0] vec_result
);

	logic busy;
	logic all_done;

	lane_if lane_bus [num_lanes] ();

	lane_dispatch #(.num_lanes(num_lanes)) u_lane_dispatch
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.oper(oper),
		.vec_a(vec_a),
		.vec_b(vec_b),
		.all_done(all_done),
		.can_accept_cmd(can_accept_cmd),
		.busy(busy),
		.lanes(lane_bus)
	);

	for (genvar i = 0; i < num_lanes; i++)
	begin : g_lane
		fpu_lane u_fpu_lane
		(
			.clk(clk),
			.reset(reset),
			.lane(lane_bus[i])
		);
	end

	lane_gather #(.num_lanes(num_lanes)) u_lane_gather
	(
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.lanes(lane_bus),
		.all_done(all_done),
		.data_valid(data_valid),
		.vec_result(vec_result)
	);

endmodule

// ==== logic/fpu_ctrl_pkg.sv ====
package fpu_ctrl_pkg;

	// code 4 was divide, which this unit does not implement.
	typedef enum logic [2:0]
	{
		op_add = 3'd0,
		op_sub = 3'd1,
		op_slt = 3'd2,
		op_mul = 3'd3,
		op_add_again = 3'd5
	} fpu_oper_t;

	typedef enum logic
	{
		st_idle,
		st_wait_for_submodule
	} lane_state_t;

endpackage

// ==== logic/fpu_lane.sv ====
module fpu_lane
	import bf16_types_pkg::*, fpu_ctrl_pkg::*;
(
	input logic clk,
	input logic reset,
	lane_if.lane lane
);

	lane_state_t state;
	fpu_oper_t oper_q;

	logic add_start;
	logic mul_start;
	logic add_valid;
	logic mul_valid;
	bf16_t add_data;
	bf16_t mul_data;

	logic sub_valid;
	bf16_t sub_data;

	bf16_exp_t a_exp;
	bf16_exp_t b_exp;
	logic a_sign;
	logic b_sign;
	logic [14:0] a_mag;
	logic [14:0] b_mag;
	logic a_less;

	assign add_start = (state == st_idle) && lane.start
		&& ((lane.oper == op_add) || (lane.oper == op_sub) || (lane.oper == op_add_again));
	assign mul_start = (state == st_idle) && lane.start && (lane.oper == op_mul);

	bf16_add u_bf16_add
	(
		.clk(clk),
		.reset(reset),
		.start(add_start),
		.subtract(lane.oper == op_sub),
		.a(lane.a),
		.b(lane.b),
		.data_valid(add_valid),
		.data(add_data)
	);

	bf16_mul u_bf16_mul
	(
		.clk(clk),
		.reset(reset),
		.start(mul_start),
		.a(lane.a),
		.b(lane.b),
		.data_valid(mul_valid),
		.data(mul_data)
	);

	// zeros of either sign compare as +0.
	always_comb
	begin
		a_exp = lane.a[14:7];
		b_exp = lane.b[14:7];
		a_sign = (a_exp == '0) ? 1'b0 : lane.a[15];
		b_sign = (b_exp == '0) ? 1'b0 : lane.b[15];
		a_mag = (a_exp == '0) ? '0 : lane.a[14:0];
		b_mag = (b_exp == '0) ? '0 : lane.b[14:0];
		if (a_sign != b_sign)
		begin
			a_less = a_sign;
		end
		else if (a_sign)
		begin
			a_less = a_mag > b_mag;
		end
		else
		begin
			a_less = a_mag < b_mag;
		end
	end

	always_comb
	begin
		case (oper_q)
		op_mul:
		begin
			sub_valid = mul_valid;
			sub_data = mul_data;
		end
		op_add, op_sub, op_add_again:
		begin
			sub_valid = add_valid;
			sub_data = add_data;
		end
		default:
		begin
			sub_valid = 1'b1;
			sub_data = '0;
		end
		endcase
	end

	// slt needs no submodule and answers straight from idle.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			lane.done <= 1'b0;
		end
		else
		begin
			lane.done <= 1'b0;
			case (state)
			st_idle:
			begin
				if (lane.start && (lane.oper == op_slt))
				begin
					lane.done <= 1'b1;
					lane.result <= {15'b0, a_less};
				end
				else if (lane.start)
				begin
					oper_q <= lane.oper;
					state <= st_wait_for_submodule;
				end
			end
			st_wait_for_submodule:
			begin
				if (sub_valid)
				begin
					lane.done <= 1'b1;
					lane.result <= sub_data;
					state <= st_idle;
				end
			end
			endcase
		end
	end

endmodule

// ==== logic/lane_dispatch.sv ====
module lane_dispatch
	import bf16_types_pkg::*, fpu_ctrl_pkg::*;
#(
	parameter int num_lanes = 4
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input fpu_oper_t oper,
	input bf16_t [num_lanes-1:0] vec_a,
	input bf16_t [num_lanes-1:0] vec_b,
	input logic all_done,
	output logic can_accept_cmd,
	output logic busy,
	lane_if.dispatch lanes [num_lanes]
);

	lane_state_t state;
	logic accept;
	logic start_q;
	fpu_oper_t oper_q;
	bf16_t [num_lanes-1:0] a_q;
	bf16_t [num_lanes-1:0] b_q;

	assign busy = (state == st_wait_for_submodule);
	assign can_accept_cmd = ~busy;
	assign accept = start && can_accept_cmd;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= accept;
			if (accept)
			begin
				state <= st_wait_for_submodule;
			end
			else if (all_done)
			begin
				state <= st_idle;
			end
		end
	end

	// the command stays on the lanes until the next one is accepted.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			oper_q <= oper;
			a_q <= vec_a;
			b_q <= vec_b;
		end
	end

	for (genvar i = 0; i < num_lanes; i++)
	begin : g_lane
		assign lanes[i].start = start_q;
		assign lanes[i].oper = oper_q;
		assign lanes[i].a = a_q[i];
		assign lanes[i].b = b_q[i];
	end

endmodule

// ==== logic/lane_gather.sv ====
module lane_gather
	import bf16_types_pkg::*;
#(
	parameter int num_lanes = 4
)
(
	input logic clk,
	input logic reset,
	input logic busy,
	lane_if.gather lanes [num_lanes],
	output logic all_done,
	output logic data_valid,
	output bf16_t [num_lanes-1:0] vec_result
);

	logic [num_lanes-1:0] lane_done;
	bf16_t [num_lanes-1:0] lane_result;
	logic [num_lanes-1:0] flags;

	for (genvar i = 0; i < num_lanes; i++)
	begin : g_lane
		assign lane_done[i] = lanes[i].done;
		assign lane_result[i] = lanes[i].result;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flags <= '0;
			all_done <= 1'b0;
			vec_result <= '0;
		end
		else
		begin
			all_done <= 1'b0;
			if (&flags)
			begin
				all_done <= 1'b1;
				flags <= '0;
			end
			else
			begin
				for (int i = 0; i < num_lanes; i++)
				begin
					if (busy && lane_done[i])
					begin
						flags[i] <= 1'b1;
						vec_result[i] <= lane_result[i];
					end
				end
			end
		end
	end

	assign data_valid = all_done;

endmodule

// ==== logic/lane_if.sv ====
interface lane_if
	import bf16_types_pkg::*, fpu_ctrl_pkg::*;
();

	logic start;
	fpu_oper_t oper;
	bf16_t a;
	bf16_t b;
	logic done;
	bf16_t result;

	modport dispatch
	(
		output start, oper, a, b
	);

	modport lane
	(
		input start, oper, a, b,
		output done, result
	);

	modport gather
	(
		input done, result
	);

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the pass line.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps \
	-f bf16_vector_unit.f \
	--top-module tb_bf16_vector_unit \
	-o sim_bf16_vector_unit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_bf16_vector_unit > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -F -x -q '** PASS **' "$log_file"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// ==== test/tb_bf16_vector_unit.sv ====
module tb_bf16_vector_unit
	import bf16_types_pkg::*, fpu_ctrl_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_lanes = 4;
	localparam int clk_period = 20;
	localparam int num_cmds = 100;
	localparam int watchdog_cycles = num_cmds * 40 + 200;
	localparam int ready_limit = 60;

	logic clk = 1'b0;
	logic reset;
	logic start;
	fpu_oper_t oper;
	bf16_t [num_lanes-1:0] vec_a;
	bf16_t [num_lanes-1:0] vec_b;
	logic can_accept_cmd;
	logic data_valid;
	bf16_t [num_lanes-1:0] vec_result;
	int error_count;
	int check_count;
	int result_count;
	int tb_errors = 0;
	int sent = 0;
	int tests_run = 0;
	int tests_failed = 0;

	always #(clk_period / 2) clk = ~clk;

	bf16_vector_unit #(.num_lanes(num_lanes)) u_bf16_vector_unit
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.oper(oper),
		.vec_a(vec_a),
		.vec_b(vec_b),
		.can_accept_cmd(can_accept_cmd),
		.data_valid(data_valid),
		.vec_result(vec_result)
	);

	vector_checker #(.num_lanes(num_lanes)) u_vector_checker
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.oper(oper),
		.vec_a(vec_a),
		.vec_b(vec_b),
		.can_accept_cmd(can_accept_cmd),
		.data_valid(data_valid),
		.vec_result(vec_result),
		.error_count(error_count),
		.check_count(check_count),
		.result_count(result_count)
	);

	function automatic bf16_t random_word(input int lo, input int hi);
		logic [7:0] exp_field;
		exp_field = 8'(lo + $urandom % (hi - lo + 1));
		return {1'($urandom), exp_field, 7'($urandom)};
	endfunction

	function automatic fpu_oper_t random_oper();
		case ($urandom % 5)
		0: return op_add;
		1: return op_sub;
		2: return op_slt;
		3: return op_mul;
		default: return op_add_again;
		endcase
	endfunction

	function automatic fpu_oper_t add_family_oper();
		case ($urandom % 3)
		0: return op_add;
		1: return op_sub;
		default: return op_add_again;
		endcase
	endfunction

	// each operand pair is biased toward the corner cases of its operation.
	function automatic logic [31:0] random_pair(input fpu_oper_t op);
		bf16_t a;
		bf16_t b;
		int unsigned mode;
		mode = $urandom % 4;
		a = random_word(1, 254);
		b = random_word(1, 254);
		case (op)
		op_mul:
		begin
			if (mode == 1)
			begin
				a = random_word(191, 254);
				b = random_word(191, 254);
			end
			else if (mode == 2)
			begin
				a = random_word(1, 63);
				b = random_word(1, 63);
			end
			else if (mode == 3)
			begin
				b = random_word(0, 0);
			end
		end
		op_slt:
		begin
			if (mode == 1)
			begin
				b = a;
			end
			else if (mode == 2)
			begin
				a = {1'b0, 8'h00, 7'($urandom)};
				b = {1'b1, 8'h00, 7'($urandom)};
			end
			else if (mode == 3)
			begin
				b = {~a[15], a[14:0]};
			end
		end
		default:
		begin
			if (mode == 1)
			begin
				b = {a[15] ^ (op != op_sub), a[14:0]};
			end
			else if (mode == 2)
			begin
				a = random_word(1, 6);
				b = {a[15] ^ (op != op_sub), a[14:7], 7'($urandom)};
			end
			else if (mode == 3)
			begin
				a = random_word(250, 254);
				b = random_word(250, 254);
				b[15] = a[15] ^ (op == op_sub);
			end
		end
		endcase
		return {a, b};
	endfunction

	task automatic wait_ready();
		int n;
		n = 0;
		while (!can_accept_cmd && (n < ready_limit))
		begin
			@(negedge clk);
			n++;
		end
		if (!can_accept_cmd)
		begin
			$display("can_accept_cmd stayed low for %0d cycles before %0t", ready_limit, $time);
			tb_errors++;
		end
	endtask

	// these starts arrive while the unit is busy and must be dropped.
	task automatic drive_ignored_starts();
		for (int n = 0; n < 8; n++)
		begin
			if (can_accept_cmd)
			begin
				break;
			end
			start = 1'b1;
			oper = random_oper();
			for (int i = 0; i < num_lanes; i++)
			begin
				vec_a[i] = random_word(1, 254);
				vec_b[i] = random_word(1, 254);
			end
			@(negedge clk);
		end
		start = 1'b0;
	endtask

	task automatic issue(input fpu_oper_t op, input logic noisy);
		logic [31:0] pair;
		wait_ready();
		oper = op;
		for (int i = 0; i < num_lanes; i++)
		begin
			pair = random_pair(op);
			vec_a[i] = pair[31:16];
			vec_b[i] = pair[15:0];
		end
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		sent++;
		if (noisy)
		begin
			drive_ignored_starts();
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		int errors_now;
		errors_now = error_count + tb_errors - errors_before;
		tests_run++;
		if (errors_now != 0)
		begin
			tests_failed++;
		end
		$display("test %s finished with %0d errors", name, errors_now);
	endtask

	task automatic run_test(input string name, input int count, input fpu_oper_t op,
		input logic mixed);
		int errors_before;
		fpu_oper_t this_op;
		errors_before = error_count + tb_errors;
		for (int n = 0; n < count; n++)
		begin
			if (mixed)
			begin
				this_op = random_oper();
			end
			else if (op == op_add)
			begin
				this_op = add_family_oper();
			end
			else
			begin
				this_op = op;
			end
			issue(this_op, mixed);
		end
		wait_ready();
		report_test(name, errors_before);
	endtask

	initial
	begin
		#(watchdog_cycles * clk_period);
		$display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		void'($urandom(69489));
		reset = 1'b1;
		start = 1'b0;
		oper = op_add;
		vec_a = '0;
		vec_b = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		report_test("reset", 0);
		run_test("add_sub", 40, op_add, 1'b0);
		run_test("mul", 30, op_mul, 1'b0);
		run_test("slt", 20, op_slt, 1'b0);
		run_test("mixed_busy_starts", 10, op_add, 1'b1);
		if (result_count != sent)
		begin
			$display("Got %0d results for %0d accepted commands", result_count, sent);
			tb_errors++;
		end
		$display("tests %0d, failed %0d, lane checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count + tb_errors);
		if ((error_count + tb_errors) == 0)
		begin
			$display("** PASS **");
		end
		else
		begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== test/vector_checker.sv ====
module vector_checker
	import bf16_types_pkg::*, fpu_ctrl_pkg::*;
#(
	parameter int num_lanes = 4,
	parameter int max_latency = 40
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input fpu_oper_t oper,
	input bf16_t [num_lanes-1:0] vec_a,
	input bf16_t [num_lanes-1:0] vec_b,
	input logic can_accept_cmd,
	input logic data_valid,
	input bf16_t [num_lanes-1:0] vec_result,
	output int error_count,
	output int check_count,
	output int result_count
);
	timeunit 1ns;
	timeprecision 1ps;

	int errors = 0;
	int checks = 0;
	int results = 0;
	int reset_cycles = 0;
	int wait_cycles = 0;
	logic pending = 1'b0;
	fpu_oper_t cmd_oper;
	bf16_t [num_lanes-1:0] cmd_a;
	bf16_t [num_lanes-1:0] cmd_b;

	assign error_count = errors;
	assign check_count = checks;
	assign result_count = results;

	// align, truncate, then normalize one bit at a time.
	function automatic bf16_t model_add(input bf16_t a, input bf16_t b, input logic sub);
		logic sign_b;
		logic sign_r;
		logic sign_s;
		int exp_a;
		int exp_b;
		int sig_a;
		int sig_b;
		int exp_r;
		int sig_r;
		int sig_s;
		sign_b = b[15] ^ sub;
		exp_a = int'(a[14:7]);
		exp_b = int'(b[14:7]);
		sig_a = (exp_a == 0) ? 0 : 128 + int'(a[6:0]);
		sig_b = (exp_b == 0) ? 0 : 128 + int'(b[6:0]);
		if (exp_a * 256 + sig_a >= exp_b * 256 + sig_b)
		begin
			sign_r = a[15];
			sign_s = sign_b;
			exp_r = exp_a;
			sig_r = sig_a;
			sig_s = sig_b >> (exp_a - exp_b);
		end
		else
		begin
			sign_r = sign_b;
			sign_s = a[15];
			exp_r = exp_b;
			sig_r = sig_b;
			sig_s = sig_a >> (exp_b - exp_a);
		end
		sig_r = (sign_r != sign_s) ? sig_r - sig_s : sig_r + sig_s;
		if (sig_r == 0)
		begin
			return 16'h0000;
		end
		if (sig_r >= 256)
		begin
			if (exp_r == 254)
			begin
				return {sign_r, 8'hff, 7'h00};
			end
			return {sign_r, 8'(exp_r + 1), 7'(sig_r >> 1)};
		end
		while (sig_r < 128)
		begin
			if (exp_r == 1)
			begin
				return 16'h0000;
			end
			sig_r = sig_r << 1;
			exp_r = exp_r - 1;
		end
		return {sign_r, 8'(exp_r), 7'(sig_r)};
	endfunction

	function automatic bf16_t model_mul(input bf16_t a, input bf16_t b);
		int product;
		int exp_r;
		int mant;
		if ((a[14:7] == 8'h00) || (b[14:7] == 8'h00))
		begin
			return 16'h0000;
		end
		product = (128 + int'(a[6:0])) * (128 + int'(b[6:0]));
		exp_r = int'(a[14:7]) + int'(b[14:7]) - 127;
		if (product >= 32768)
		begin
			exp_r = exp_r + 1;
			mant = product >> 8;
		end
		else
		begin
			mant = product >> 7;
		end
		if (exp_r <= 0)
		begin
			return 16'h0000;
		end
		if (exp_r >= 255)
		begin
			return {a[15] ^ b[15], 8'hff, 7'h00};
		end
		return {a[15] ^ b[15], 8'(exp_r), 7'(mant)};
	endfunction

	// maps a word to its signed place on the number line, and every zero maps to 0.
	function automatic int order_key(input bf16_t x);
		if (x[14:7] == 8'h00)
		begin
			return 0;
		end
		return x[15] ? -int'(x[14:0]) : int'(x[14:0]);
	endfunction

	function automatic bf16_t model_result(input fpu_oper_t op, input bf16_t a, input bf16_t b);
		case (op)
		op_add, op_add_again: return model_add(a, b, 1'b0);
		op_sub: return model_add(a, b, 1'b1);
		op_mul: return model_mul(a, b);
		op_slt: return (order_key(a) < order_key(b)) ? 16'd1 : 16'd0;
		default: return 16'h0000;
		endcase
	endfunction

	task automatic check_vector();
		bf16_t expected;
		if (!pending)
		begin
			$display("data_valid pulsed at %0t with no accepted command outstanding", $time);
			errors++;
		end
		else
		begin
			for (int i = 0; i < num_lanes; i++)
			begin
				expected = model_result(cmd_oper, cmd_a[i], cmd_b[i]);
				checks++;
				if (vec_result[i] !== expected)
				begin
					$display("Mismatch at %0t: lane %0d %s a=%h b=%h expected %h got %h",
						$time, i, cmd_oper.name(), cmd_a[i], cmd_b[i], expected, vec_result[i]);
					errors++;
				end
			end
		end
		pending = 1'b0;
		results++;
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			reset_cycles++;
			pending = 1'b0;
			if ((reset_cycles > 1) && ((can_accept_cmd !== 1'b1) || (data_valid !== 1'b0)
				|| (vec_result !== '0)))
			begin
				$display("Mismatch at %0t: outputs are not at their reset values", $time);
				errors++;
			end
		end
		else
		begin
			// a command in flight holds the unit busy until after its data_valid.
			if (pending && (can_accept_cmd !== 1'b0))
			begin
				$display("Mismatch at %0t: can_accept_cmd is high while a command is outstanding",
					$time);
				errors++;
			end
			if (data_valid)
			begin
				check_vector();
			end
			if (start && can_accept_cmd)
			begin
				cmd_oper = oper;
				cmd_a = vec_a;
				cmd_b = vec_b;
				pending = 1'b1;
				wait_cycles = 0;
			end
			else if (pending)
			begin
				wait_cycles++;
				if (wait_cycles > max_latency)
				begin
					$display("No data_valid within %0d cycles of the %s command accepted before %0t",
						max_latency, cmd_oper.name(), $time);
					errors++;
					pending = 1'b0;
				end
			end
		end
	end

endmodule
